// ==== halfband_sym.sv ====
module halfband_sym import hb_pkg::*; (
    input  logic    sys_clk,
    input  logic    reset,
    input  logic    clear,
    input  logic    tick2_en,
    input  sample_t x_in,
    output sample_t y
);

    sample_t                       x_dl   [TAP_COUNT];   // delay line, 1s17
    sample_t                       sum_l1 [SUM_L1];      // symmetric pairs, last is centre
    logic signed [2*SMP_W-1:0]     prod   [SUM_L1];      // full products, 2s34
    sample_t                       sum_l2 [SUM_L2];
    sample_t                       sum_l3 [SUM_L3];
    sample_t                       sum_l4;
    logic                          flush;

    assign flush = reset || clear;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input stage and delay line
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys_clk) begin
        if (flush) begin
            for (int i = 0; i < TAP_COUNT; i++) begin
                x_dl[i] <= '0;
            end
        end else if (tick2_en) begin
            x_dl[0] <= x_in >>> 1;            // halve so the pre-add has a bit of headroom
            for (int i = 1; i < TAP_COUNT; i++) begin
                x_dl[i] <= x_dl[i-1];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pre-add of mirrored taps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys_clk) begin
        if (flush) begin
            for (int i = 0; i < SUM_L1; i++) begin
                sum_l1[i] <= '0;
            end
        end else if (tick2_en) begin
            for (int i = 0; i < SUM_L1 - 1; i++) begin
                sum_l1[i] <= x_dl[i] + x_dl[TAP_COUNT-1-i];   // wraps at 18 bits
            end
            sum_l1[SUM_L1-1] <= x_dl[SUM_L1-1];               // centre tap has no partner
        end
    end

    // multipliers sit in front of the second adder level
    always_comb begin
        for (int i = 0; i < SUM_L1; i++) begin
            prod[i] = HB_COEF[i] * sum_l1[i];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // adder tree
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge sys_clk) begin
        if (flush) begin
            for (int i = 0; i < SUM_L2; i++) begin
                sum_l2[i] <= '0;
            end
        end else if (tick2_en) begin
            // keep product bits 33 down to 16, back to 1s17 by truncation
            for (int i = 0; i < SUM_L2; i++) begin
                sum_l2[i] <= sample_t'(prod[2*i][PROD_SHIFT +: SMP_W])
                           + sample_t'(prod[2*i+1][PROD_SHIFT +: SMP_W]);
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (flush) begin
            for (int i = 0; i < SUM_L3; i++) begin
                sum_l3[i] <= '0;
            end
        end else if (tick2_en) begin
            for (int i = 0; i < SUM_L3; i++) begin
                sum_l3[i] <= sum_l2[2*i] + sum_l2[2*i+1];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (flush) begin
            sum_l4 <= '0;
            y      <= '0;
        end else if (tick2_en) begin
            sum_l4 <= sum_l3[0] + sum_l3[1];
            y      <= sum_l4;                 // output register, holds between ticks
        end
    end

endmodule

// ==== hb_interp_top.sv ====
module hb_interp_top import hb_pkg::*; (
    input  logic        sys_clk,
    input  logic        reset,
    input  logic        run,
    input  smp_strobe_t in_smp,
    output smp_strobe_t out_smp
);

    logic    tick2_en;
    logic    tick1_en;
    logic    clear;
    logic    out_go;
    sample_t stuff_data;
    sample_t filt_y;

    rate_timer u_rate_timer (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .tick2_en (tick2_en),
        .tick1_en (tick1_en)
    );

    interp_ctrl u_interp_ctrl (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .run      (run),
        .tick2_en (tick2_en),
        .tick1_en (tick1_en),
        .clear    (clear),
        .out_go   (out_go)
    );

    zero_stuffer u_zero_stuffer (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .clear      (clear),
        .in_smp     (in_smp),
        .tick2_en   (tick2_en),
        .tick1_en   (tick1_en),
        .stuff_data (stuff_data)
    );

    halfband_sym u_halfband_sym (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .clear    (clear),
        .tick2_en (tick2_en),
        .x_in     (stuff_data),
        .y        (filt_y)
    );

    // y settles on the tick edge, out_go marks the cycle right after it
    assign out_smp.valid = out_go;
    assign out_smp.data  = filt_y;

endmodule

// ==== hb_pkg.sv ====
package hb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sample format and strobe bundle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int SMP_W = 18;                // 1s17 fixed point

    typedef logic signed [SMP_W-1:0] sample_t;

    // one sample with its single-cycle valid strobe, no back-pressure
    typedef struct packed {
        logic    valid;
        sample_t data;
    } smp_strobe_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rate and sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int TICK_DIV = 4;              // sys_clk cycles per double-rate tick

    // delay line depth plus the five register stages behind it, so the
    // pipeline holds only post-clear data once this many ticks have passed
    localparam int FILL_TICKS = 20;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // halfband filter shape
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int TAP_COUNT = 15;            // odd length, symmetric
    localparam int SUM_L1    = 8;             // seven pre-added pairs plus the centre
    localparam int SUM_L2    = 4;
    localparam int SUM_L3    = 2;

    // 1s17 times 1s17 gives a 36 bit product, bits 33 down to 16 are kept
    localparam int PROD_SHIFT = 16;

    // unique taps in 1s17, index 0 pairs the outermost taps
    // odd taps are zero as usual for a halfband, index 7 is the centre
    localparam sample_t HB_COEF [SUM_L1] = '{
        -18'sd22,
        18'sd0,
        18'sd205,
        18'sd0,
        -18'sd995,
        18'sd0,
        18'sd4908,
        18'sd8192
    };

endpackage

// ==== interp_ctrl.sv ====
module interp_ctrl import hb_pkg::*; (
    input  logic sys_clk,
    input  logic reset,
    input  logic run,
    input  logic tick2_en,
    input  logic tick1_en,
    output logic clear,
    output logic out_go
);

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        RUN
    } ctrl_state_t;

    ctrl_state_t                   state;
    ctrl_state_t                   state_nxt;
    logic [$clog2(FILL_TICKS)-1:0] fill_cnt;  // double-rate ticks seen since FILL began
    logic                          fill_done;

    assign fill_done = tick2_en && (fill_cnt == $bits(fill_cnt)'(FILL_TICKS - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (run && tick1_en) state_nxt = FILL;   // start on a sample boundary
            FILL: if (fill_done) state_nxt = RUN;
            RUN:  state_nxt = RUN;
            default: state_nxt = IDLE;
        endcase
        if (!run) begin
            state_nxt = IDLE;                 // dropping run aborts from anywhere
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            fill_cnt <= '0;
        end else if (state != FILL) begin
            fill_cnt <= '0;
        end else if (tick2_en) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // clear lands in the first FILL cycle and wipes the stuffer and the filter
    // out_go follows each tick by one cycle, which is when the new y is visible
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            clear  <= 1'b0;
            out_go <= 1'b0;
        end else begin
            clear  <= (state == IDLE) && (state_nxt == FILL);
            out_go <= tick2_en && (state_nxt == RUN);
        end
    end

endmodule

// ==== rate_timer.sv ====
module rate_timer import hb_pkg::*; (
    input  logic sys_clk,
    input  logic reset,
    output logic tick2_en,
    output logic tick1_en
);

    logic [$clog2(TICK_DIV)-1:0] cyc_cnt;     // position inside one double-rate period
    logic                        phase;       // high on the tick that also starts a sample period
    logic                        wrap;

    assign wrap = (cyc_cnt == $bits(cyc_cnt)'(TICK_DIV - 1));

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            cyc_cnt <= '0;
            phase   <= 1'b0;
        end else begin
            if (wrap) begin
                cyc_cnt <= '0;
                phase   <= ~phase;            // flips once per tick
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    // both enables come out of one counter so the two rates can never drift apart
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            tick2_en <= 1'b0;
            tick1_en <= 1'b0;
        end else begin
            tick2_en <= wrap;
            tick1_en <= wrap & phase;         // every second double-rate tick
        end
    end

endmodule

// ==== tb.f ====
hb_pkg.sv
rate_timer.sv
interp_ctrl.sv
zero_stuffer.sv
halfband_sym.sv
hb_interp_top.sv
tb_hb_interp.sv

// ==== tb_hb_interp.sv ====
module tb_hb_interp import hb_pkg::*; ();

    // about eight cycles per streamed input plus the fill for every stream test
    localparam int TEST_CYCLES = 50 + 200 + 8 * (24 + 16 + 64 + 30 + 20) + 4 * 120;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic        sys_clk;
    logic        reset;
    logic        run;
    smp_strobe_t in_smp;
    smp_strobe_t out_smp;
    int          since_rst;                   // edges counted from reset release
    int          errors;
    int          tests_done;
    logic        collecting;
    sample_t     stim_q[$];                   // input samples of the current stream
    sample_t     got_q[$];
    int          got_at[$];                   // since_rst value at each collected strobe

    hb_interp_top u_dut (
        .sys_clk (sys_clk),
        .reset   (reset),
        .run     (run),
        .in_smp  (in_smp),
        .out_smp (out_smp)
    );

    initial sys_clk = 1'b0;
    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        if (reset) begin
            since_rst <= 0;
        end else begin
            since_rst <= since_rst + 1;
        end
    end

    // collect output samples on valid
    always @(posedge sys_clk) begin
        if (collecting && out_smp.valid) begin
            got_q.push_back(out_smp.data);
            got_at.push_back(since_rst);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // output j sees the zero-stuffed stream from index j-1 to j+13
    // index -1 is the zero that clear leaves in the stuffer
    // odd indices carry the inputs and even indices the inserted zeros
    function automatic sample_t model_out(input int j);
        sample_t dl [TAP_COUNT];
        sample_t pre;
        sample_t acc;
        longint  prod;
        int      k;
        acc = '0;
        for (int t = 0; t < TAP_COUNT; t++) begin
            k = j + TAP_COUNT - 2 - t;
            if (k >= 0 && k % 2 == 1) begin
                dl[t] = stim_q[k / 2] >>> 1;
            end else begin
                dl[t] = '0;
            end
        end
        for (int i = 0; i < SUM_L1; i++) begin
            if (i == SUM_L1 - 1) begin
                pre = dl[i];                  // centre tap stands alone
            end else begin
                pre = dl[i] + dl[TAP_COUNT - 1 - i];
            end
            prod = longint'(HB_COEF[i]) * longint'(pre);
            acc = acc + sample_t'(prod >>> PROD_SHIFT);   // the sum wraps mod 2**18
        end
        return acc;
    endfunction

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_strobe(input string name, input smp_strobe_t got, input smp_strobe_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_done++;
        if (errors == err_before) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s had %0d errors", name, errors - err_before);
        end
    endtask

    // returns on an edge where tick1_en and tick2_en act together
    task automatic wait_sample_tick();
        do begin
            @(posedge sys_clk);
        end while (since_rst < 2 * TICK_DIV || since_rst % (2 * TICK_DIV) != 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // FILL starts one sample period after run goes high, each input is strobed
    // in the middle of the sample period before the tick that takes it
    task automatic run_stream(input string name);
        int err_before;
        int n_out;
        err_before = errors;
        n_out = 2 * stim_q.size() - (TAP_COUNT - 2);
        got_q.delete();
        got_at.delete();
        wait_sample_tick();
        collecting <= 1'b1;
        run <= 1'b1;
        repeat (2 * TICK_DIV + 3) @(posedge sys_clk);
        foreach (stim_q[i]) begin
            in_smp.valid <= 1'b1;
            in_smp.data  <= stim_q[i];
            @(posedge sys_clk);
            in_smp.valid <= 1'b0;
            repeat (2 * TICK_DIV - 1) @(posedge sys_clk);
        end
        while (got_q.size() < n_out) @(posedge sys_clk);
        collecting <= 1'b0;
        run <= 1'b0;
        for (int j = 0; j < n_out; j++) begin
            check_sample($sformatf("out_smp.data[%0d]", j), got_q[j], model_out(j));
        end
        report_test(name, err_before);
    endtask

    task automatic test_reset_state();
        int err_before;
        err_before = errors;
        @(posedge sys_clk);
        @(posedge sys_clk);
        check_strobe("out_smp", out_smp, '0);
        reset <= 1'b0;
        repeat (10 * TICK_DIV) begin
            @(posedge sys_clk);
            check_strobe("out_smp", out_smp, '0);
        end
        report_test("reset_state", err_before);
    endtask

    task automatic test_strobe_rate();
        int err_before;
        int start_at;
        int late;
        err_before = errors;
        got_q.delete();
        got_at.delete();
        collecting <= 1'b1;
        wait_sample_tick();
        start_at = since_rst;
        run <= 1'b1;
        while (got_at.size() < 16) @(posedge sys_clk);
        collecting <= 1'b0;
        run <= 1'b0;
        // one sample period to enter FILL, then FILL_TICKS ticks, then one cycle
        check_count("first out_smp.valid", got_at[0],
                    start_at + 2 * TICK_DIV + FILL_TICKS * TICK_DIV + 1);
        for (int i = 1; i < 16; i++) begin
            check_count("out_smp.valid spacing", got_at[i] - got_at[i-1], TICK_DIV);
        end
        @(posedge sys_clk);                   // a strobe already under way may still show here
        late = 0;
        repeat (10 * TICK_DIV) begin
            @(posedge sys_clk);
            if (out_smp.valid !== 1'b0) late++;
        end
        check_count("out_smp.valid after run low", late, 0);
        report_test("strobe_rate", err_before);
    endtask

    task automatic test_impulse();
        stim_q.delete();
        for (int i = 0; i < 24; i++) begin
            stim_q.push_back(i == 8 ? 18'sd65536 : 18'sd0);   // late enough to show all taps
        end
        run_stream("impulse");
    endtask

    task automatic test_dc();
        stim_q.delete();
        repeat (16) stim_q.push_back(18'sd40000);
        run_stream("dc");
    endtask

    task automatic test_random();
        stim_q.delete();
        repeat (64) stim_q.push_back(sample_t'($urandom));
        run_stream("random");
    endtask

    // a full-scale stream fills the pipeline, then run drops and a new stream starts
    task automatic test_restart();
        wait_sample_tick();
        run <= 1'b1;
        in_smp.valid <= 1'b1;
        repeat (30 * 2 * TICK_DIV) begin
            in_smp.data <= sample_t'($urandom);
            @(posedge sys_clk);
        end
        in_smp.valid <= 1'b0;
        run <= 1'b0;
        stim_q.delete();
        repeat (20) stim_q.push_back(sample_t'($urandom));
        run_stream("restart");
    endtask

    initial begin
        reset      = 1'b1;
        run        = 1'b0;
        in_smp     = '0;
        collecting = 1'b0;
        errors     = 0;
        tests_done = 0;
        void'($urandom(212));
        test_reset_state();
        test_strobe_rate();
        test_impulse();
        test_dc();
        test_random();
        test_restart();
        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== zero_stuffer.sv ====
module zero_stuffer import hb_pkg::*; (
    input  logic        sys_clk,
    input  logic        reset,
    input  logic        clear,
    input  smp_strobe_t in_smp,
    input  logic        tick2_en,
    input  logic        tick1_en,
    output sample_t     stuff_data
);

    sample_t held;                            // last sample strobed in by the source

    always_ff @(posedge sys_clk) begin
        if (reset || clear) begin
            held <= '0;
        end else if (in_smp.valid) begin
            held <= in_smp.data;              // a second strobe in one period simply overwrites
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 2x upsampling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // on a sample-phase tick the held value goes out, on the other tick a zero
    // the filter input stage picks this up on the following tick
    always_ff @(posedge sys_clk) begin
        if (reset || clear) begin
            stuff_data <= '0;
        end else if (tick2_en) begin
            if (tick1_en) begin
                stuff_data <= held;
            end else begin
                stuff_data <= '0;
            end
        end
    end

endmodule
